/* logic/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

    // Bus geometry
    localparam int WORD_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int NUM_LANES = 4;
    localparam int OFF_W     = 2;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BYTE_W-1:0]    byte_t;
    typedef logic [NUM_LANES-1:0] byte_en_t;
    typedef logic [OFF_W-1:0]     byte_off_t;

    // Access width and signedness, shared by loads and stores
    typedef logic [2:0] load_type_t;

    localparam load_type_t LT_LB   = 3'd0;
    localparam load_type_t LT_LH   = 3'd1;
    localparam load_type_t LT_LW   = 3'd2;
    localparam load_type_t LT_LBU  = 3'd3;
    localparam load_type_t LT_LHU  = 3'd4;
    localparam load_type_t LT_NONE = 3'd7;

    // Writeback source select
    typedef logic [2:0] w_sel_t;

    localparam w_sel_t WSEL_DLOAD = 3'd0;
    localparam w_sel_t WSEL_PC4   = 3'd1;
    localparam w_sel_t WSEL_IMM_U = 3'd2;
    localparam w_sel_t WSEL_ALU   = 3'd3;

    // Standard enable patterns, shifted up by the byte offset
    localparam byte_en_t BE_BYTE = 4'b0001;
    localparam byte_en_t BE_HALF = 4'b0011;
    localparam byte_en_t BE_WORD = 4'b1111;
    localparam byte_en_t BE_NONE = 4'b0000;

    // Sign bit positions within the aligned load bytes
    localparam int BYTE_MSB = BYTE_W - 1;
    localparam int HALF_MSB = 2 * BYTE_W - 1;

endpackage

`default_nettype wire

/* logic/mem_access_if.sv */
`default_nettype none

interface mem_access_if import mem_stage_pkg::*; ();

    // Decoded access shared by the lanes and the extender
    load_type_t load_type;
    byte_off_t  byte_off;
    byte_en_t   byte_en;
    word_t      store_data;

    modport decoder (
        output load_type,
        output byte_off,
        output byte_en,
        output store_data
    );

    modport lane (
        input byte_off,
        input store_data
    );

    modport extender (
        input load_type,
        input byte_off
    );

endinterface

`default_nettype wire

/* logic/mem_access_decoder.sv */
`default_nettype none

module mem_access_decoder import mem_stage_pkg::*; (
    input  wire logic       dren,
    input  wire logic       dwen,
    input  wire logic       suppress_data,
    input  wire load_type_t load_type,
    input  wire word_t      addr,
    input  wire word_t      rs2_data,
    input  wire logic       bus_error,
    mem_access_if.decoder   acc,
    output logic            bus_ren,
    output logic            bus_wen,
    output logic            mal_l,
    output logic            mal_s,
    output logic            fault_l,
    output logic            fault_s
);

    byte_off_t offset;
    logic      mal_addr;
    byte_en_t  base_en;
    byte_en_t  byte_en;

    assign offset = addr[OFF_W-1:0];

    // Width alignment check
    always_comb begin
        case (load_type)
            LT_LW: begin
                mal_addr = (offset != 2'b00);
            end
            LT_LH, LT_LHU: begin
                mal_addr = offset[0];
            end
            default: begin
                mal_addr = 1'b0;
            end
        endcase
    end

    // Unshifted enable pattern for the access width
    always_comb begin
        case (load_type)
            LT_LB, LT_LBU: begin
                base_en = BE_BYTE;
            end
            LT_LH, LT_LHU: begin
                base_en = BE_HALF;
            end
            LT_LW: begin
                base_en = BE_WORD;
            end
            default: begin
                base_en = BE_NONE;
            end
        endcase
    end

    // Misaligned accesses touch no lanes
    always_comb begin
        if (mal_addr) begin
            byte_en = BE_NONE;
        end else begin
            byte_en = base_en << offset;
        end
    end

    assign acc.load_type  = load_type;
    assign acc.byte_off   = offset;
    assign acc.byte_en    = byte_en;
    assign acc.store_data = rs2_data;

    // Suppressed accesses never reach the bus
    assign bus_ren = dren && !suppress_data;
    assign bus_wen = dwen && !suppress_data;

    assign mal_l = dren && mal_addr;
    assign mal_s = dwen && mal_addr;

    // Bus errors reported against the access direction
    assign fault_l = dren && bus_error;
    assign fault_s = dwen && bus_error;

endmodule

`default_nettype wire

/* logic/mem_byte_lane.sv */
`default_nettype none

module mem_byte_lane import mem_stage_pkg::*; #(
    parameter int LANE = 0
) (
    mem_access_if.lane acc,
    input  wire word_t rdata,
    output byte_t      store_byte,
    output byte_t      load_byte
);

    localparam byte_off_t LANE_IDX = byte_off_t'(LANE);

    byte_t [NUM_LANES-1:0] store_bytes;
    byte_t [NUM_LANES-1:0] read_bytes;
    byte_off_t             store_sel;
    byte_off_t             load_sel;

    // View both words as lane arrays
    assign store_bytes = acc.store_data;
    assign read_bytes  = rdata;

    // Store side
    // lane LANE carries rs2 byte (LANE - offset), wrapping mod 4
    assign store_sel = LANE_IDX - acc.byte_off;

    // Load side
    // lane LANE collects bus byte (LANE + offset) so the
    // addressed bytes land at the bottom of the word
    assign load_sel = LANE_IDX + acc.byte_off;

    always_comb begin
        store_byte = store_bytes[store_sel];
    end

    always_comb begin
        load_byte = read_bytes[load_sel];
    end

endmodule

`default_nettype wire

/* logic/mem_load_extender.sv */
`default_nettype none

module mem_load_extender import mem_stage_pkg::*; (
    mem_access_if.extender        acc,
    input  wire byte_t [NUM_LANES-1:0] load_bytes,
    input  wire w_sel_t           w_sel,
    input  wire word_t            pc4,
    input  wire word_t            imm_u,
    input  wire word_t            alu_result,
    input  wire logic             reg_write_in,
    input  wire logic             suppress_data,
    output word_t                 reg_wdata,
    output logic                  reg_write
);

    word_t aligned;
    word_t dload_ext;
    logic  byte_sign;
    logic  half_sign;

    // Lanes already moved the addressed bytes to the low end
    assign aligned = load_bytes;

    assign byte_sign = aligned[BYTE_MSB];
    assign half_sign = aligned[HALF_MSB];

    // Width and sign handling
    always_comb begin
        case (acc.load_type)
            LT_LB: begin
                dload_ext = {{(WORD_W-BYTE_W){byte_sign}}, aligned[BYTE_MSB:0]};
            end
            LT_LH: begin
                dload_ext = {{(WORD_W-2*BYTE_W){half_sign}}, aligned[HALF_MSB:0]};
            end
            LT_LBU: begin
                dload_ext = {{(WORD_W-BYTE_W){1'b0}}, aligned[BYTE_MSB:0]};
            end
            LT_LHU: begin
                dload_ext = {{(WORD_W-2*BYTE_W){1'b0}}, aligned[HALF_MSB:0]};
            end
            LT_LW: begin
                dload_ext = aligned;
            end
            default: begin
                dload_ext = '0;
            end
        endcase
    end

    // Writeback source
    always_comb begin
        case (w_sel)
            WSEL_DLOAD: begin
                reg_wdata = dload_ext;
            end
            WSEL_PC4: begin
                reg_wdata = pc4;
            end
            WSEL_IMM_U: begin
                reg_wdata = imm_u;
            end
            WSEL_ALU: begin
                reg_wdata = alu_result;
            end
            default: begin
                reg_wdata = '0;
            end
        endcase
    end

    // No register update for a squashed instruction
    assign reg_write = reg_write_in && !suppress_data;

endmodule

`default_nettype wire

/* logic/fence_flush_tracker.sv */
`default_nettype none

module fence_flush_tracker (
    input  wire logic CLK,
    input  wire logic nRST,
    input  wire logic ifence,
    input  wire logic iflush_done,
    input  wire logic dflush_done,
    output logic      icache_flush,
    output logic      dcache_flush,
    output logic      fence_stall
);

    logic ifence_reg;
    logic ifence_pulse;
    logic iflushed;
    logic iflushed_next;
    logic dflushed;
    logic dflushed_next;

    // Only the first cycle of a fence starts a flush
    assign ifence_pulse = ifence && !ifence_reg;

    assign icache_flush = ifence_pulse;
    assign dcache_flush = ifence_pulse;

    always_comb begin
        iflushed_next = iflushed;
        dflushed_next = dflushed;
        if (ifence_pulse) begin
            iflushed_next = 1'b0;
            dflushed_next = 1'b0;
        end
        // Done strobes win over a new fence in the same cycle
        if (iflush_done) begin
            iflushed_next = 1'b1;
        end
        if (dflush_done) begin
            dflushed_next = 1'b1;
        end
    end

    // Caches start out clean
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ifence_reg <= 1'b0;
            iflushed   <= 1'b1;
            dflushed   <= 1'b1;
        end else begin
            ifence_reg <= ifence;
            iflushed   <= iflushed_next;
            dflushed   <= dflushed_next;
        end
    end

    // Hold the fence until both caches are done
    assign fence_stall = ifence_reg && !(iflushed && dflushed);

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`default_nettype none

module mem_stage import mem_stage_pkg::*; (
    input  wire logic       CLK,
    input  wire logic       nRST,
    // Stage register fields
    input  wire logic       dren,
    input  wire logic       dwen,
    input  wire logic       suppress_data,
    input  wire load_type_t load_type,
    input  wire word_t      alu_result,
    input  wire word_t      rs2_data,
    input  wire w_sel_t     w_sel,
    input  wire word_t      pc4,
    input  wire word_t      imm_u,
    input  wire logic       reg_write_in,
    input  wire logic       ifence,
    // Data bus
    input  wire word_t      bus_rdata,
    input  wire logic       bus_error,
    output logic            bus_ren,
    output logic            bus_wen,
    output word_t           bus_addr,
    output byte_en_t        bus_byte_en,
    output word_t           bus_wdata,
    // Writeback
    output word_t           reg_wdata,
    output logic            reg_write,
    // Exceptions
    output logic            mal_l,
    output logic            mal_s,
    output logic            fault_l,
    output logic            fault_s,
    // Cache control
    input  wire logic       iflush_done,
    input  wire logic       dflush_done,
    output logic            icache_flush,
    output logic            dcache_flush,
    output logic            fence_stall
);

    mem_access_if acc_if ();

    byte_t [NUM_LANES-1:0] store_bytes;
    byte_t [NUM_LANES-1:0] load_bytes;

    assign bus_addr    = alu_result;
    assign bus_byte_en = acc_if.byte_en;
    assign bus_wdata   = store_bytes;

    mem_access_decoder decoder_inst (
        .dren          (dren),
        .dwen          (dwen),
        .suppress_data (suppress_data),
        .load_type     (load_type),
        .addr          (alu_result),
        .rs2_data      (rs2_data),
        .bus_error     (bus_error),
        .acc           (acc_if.decoder),
        .bus_ren       (bus_ren),
        .bus_wen       (bus_wen),
        .mal_l         (mal_l),
        .mal_s         (mal_s),
        .fault_l       (fault_l),
        .fault_s       (fault_s)
    );

    // One steering slice per bus byte
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        mem_byte_lane #(
            .LANE (i)
        ) byte_lane_inst (
            .acc        (acc_if.lane),
            .rdata      (bus_rdata),
            .store_byte (store_bytes[i]),
            .load_byte  (load_bytes[i])
        );
    end

    mem_load_extender extender_inst (
        .acc           (acc_if.extender),
        .load_bytes    (load_bytes),
        .w_sel         (w_sel),
        .pc4           (pc4),
        .imm_u         (imm_u),
        .alu_result    (alu_result),
        .reg_write_in  (reg_write_in),
        .suppress_data (suppress_data),
        .reg_wdata     (reg_wdata),
        .reg_write     (reg_write)
    );

    fence_flush_tracker tracker_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .ifence       (ifence),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .fence_stall  (fence_stall)
    );

endmodule

`default_nettype wire

/* sim/mem_stage_tb.sv */
`default_nettype none

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int FAULT_CYCLES = 8;
    localparam int FENCE_CYCLES = 64;

    logic       CLK = 1'b0;
    logic       nRST;
    logic       dren;
    logic       dwen;
    logic       suppress_data;
    load_type_t load_type;
    word_t      alu_result;
    word_t      rs2_data;
    w_sel_t     w_sel;
    word_t      pc4;
    word_t      imm_u;
    logic       reg_write_in;
    logic       ifence;
    word_t      bus_rdata;
    logic       bus_error;
    logic       bus_ren;
    logic       bus_wen;
    word_t      bus_addr;
    byte_en_t   bus_byte_en;
    word_t      bus_wdata;
    word_t      reg_wdata;
    logic       reg_write;
    logic       mal_l;
    logic       mal_s;
    logic       fault_l;
    logic       fault_s;
    logic       iflush_done;
    logic       dflush_done;
    logic       icache_flush;
    logic       dcache_flush;
    logic       fence_stall;

    string lines[$];
    int    cycle_count = 0;
    int    timeout_limit = RESET_CYCLES + FAULT_CYCLES + FENCE_CYCLES;

    mem_stage mem_stage_inst (.*);

    always #50 CLK = ~CLK;

    // Watchdog on the total cycle budget
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_byte_en(input string name, input byte_en_t expected,
                                 input byte_en_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    // Keep data lines only, skipping comments and blanks
    task automatic load_stimulus();
        int    fd;
        int    code;
        string line;
        fd = $fopen("sim/mem_stage_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("** FAIL **");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 1 && line.getc(0) != "#") begin
                lines.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    task automatic run_vector(input string line);
        logic       v_dren;
        logic       v_dwen;
        logic       v_sup;
        load_type_t v_lt;
        word_t      v_addr;
        word_t      v_rs2;
        w_sel_t     v_wsel;
        word_t      v_pc4;
        word_t      v_imm;
        logic       v_rwin;
        word_t      v_rdata;
        byte_en_t   e_be;
        word_t      e_wdata;
        word_t      e_regw;
        logic       e_rw;
        logic       e_mall;
        logic       e_mals;
        int         fields;
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         v_dren, v_dwen, v_sup, v_lt, v_addr, v_rs2, v_wsel, v_pc4,
                         v_imm, v_rwin, v_rdata, e_be, e_wdata, e_regw, e_rw,
                         e_mall, e_mals);
        if (fields != 17) begin
            $display("Stimulus line has %0d fields instead of 17: %s", fields, line);
            $display("** FAIL **");
            $fatal(1);
        end
        @(posedge CLK);
        dren          <= v_dren;
        dwen          <= v_dwen;
        suppress_data <= v_sup;
        load_type     <= v_lt;
        alu_result    <= v_addr;
        rs2_data      <= v_rs2;
        w_sel         <= v_wsel;
        pc4           <= v_pc4;
        imm_u         <= v_imm;
        reg_write_in  <= v_rwin;
        bus_rdata     <= v_rdata;
        @(negedge CLK);
        check_byte_en("bus_byte_en", e_be, bus_byte_en);
        check_word("bus_wdata", e_wdata, bus_wdata);
        check_word("reg_wdata", e_regw, reg_wdata);
        check_bit("reg_write", e_rw, reg_write);
        check_bit("mal_l", e_mall, mal_l);
        check_bit("mal_s", e_mals, mal_s);
        // Strobes and address follow the inputs directly
        check_bit("bus_ren", v_dren && !v_sup, bus_ren);
        check_bit("bus_wen", v_dwen && !v_sup, bus_wen);
        check_word("bus_addr", v_addr, bus_addr);
    endtask

    // All combinations of bus_error, dren and dwen
    task automatic check_faults();
        for (int i = 0; i < FAULT_CYCLES; i++) begin
            @(posedge CLK);
            suppress_data <= 1'b0;
            load_type     <= LT_NONE;
            bus_error     <= i[2];
            dren          <= i[1];
            dwen          <= i[0];
            @(negedge CLK);
            check_bit("fault_l", i[2] && i[1], fault_l);
            check_bit("fault_s", i[2] && i[0], fault_s);
        end
    endtask

    task automatic fence_step(input logic fence_in, input logic i_done, input logic d_done,
                              input logic flush, input logic stall);
        @(posedge CLK);
        ifence      <= fence_in;
        iflush_done <= i_done;
        dflush_done <= d_done;
        @(negedge CLK);
        check_bit("icache_flush", flush, icache_flush);
        check_bit("dcache_flush", flush, dcache_flush);
        check_bit("fence_stall", stall, fence_stall);
    endtask

    task automatic run_fence_sequence();
        // Quiet after reset
        fence_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        fence_step(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        // Data cache finishes first
        fence_step(1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        fence_step(1'b1, 1'b1, 1'b0, 1'b0, 1'b1);
        // Stall drops the cycle after the later strobe
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        // Held fence gives no second flush
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        fence_step(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        fence_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        nRST          = 1'b0;
        dren          = 1'b0;
        dwen          = 1'b0;
        suppress_data = 1'b0;
        load_type     = LT_NONE;
        alu_result    = '0;
        rs2_data      = '0;
        w_sel         = WSEL_ALU;
        pc4           = '0;
        imm_u         = '0;
        reg_write_in  = 1'b0;
        ifence        = 1'b0;
        bus_rdata     = '0;
        bus_error     = 1'b0;
        iflush_done   = 1'b0;
        dflush_done   = 1'b0;
        load_stimulus();
        timeout_limit = RESET_CYCLES + lines.size() + FAULT_CYCLES + FENCE_CYCLES;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        run_fence_sequence();
        foreach (lines[i]) begin
            run_vector(lines[i]);
        end
        check_faults();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
logic/mem_stage_pkg.sv
logic/mem_access_if.sv
logic/mem_access_decoder.sv
logic/mem_byte_lane.sv
logic/mem_load_extender.sv
logic/fence_flush_tracker.sv
logic/mem_stage.sv
sim/mem_stage_tb.sv

/* Makefile */
TOP := mem_stage_tb

.PHONY: sim clean

sim:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

/* sim/mem_stage_stimulus.txt */
# dren dwen sup lt addr rs2 wsel pc4 imm_u rwin rdata | be wdata reg_wdata reg_write mal_l mal_s
# hex fields; lt 0=LB 1=LH 2=LW 3=LBU 4=LHU 7=none; wsel 0=load 1=pc4 2=imm_u 3=alu
1 0 0 0 00000100 11223344 0 00001004 12345000 1 c3a57e19 1 11223344 00000019 1 0 0
1 0 0 0 00000101 11223344 0 00001004 12345000 1 c3a57e19 2 22334411 0000007e 1 0 0
1 0 0 0 00000102 11223344 0 00001004 12345000 1 c3a57e19 4 33441122 ffffffa5 1 0 0
1 0 0 0 00000103 11223344 0 00001004 12345000 1 c3a57e19 8 44112233 ffffffc3 1 0 0
1 0 0 1 00000100 11223344 0 00001004 12345000 1 c3a57e19 3 11223344 00007e19 1 0 0
1 0 0 1 00000102 11223344 0 00001004 12345000 1 c3a57e19 c 33441122 ffffc3a5 1 0 0
1 0 0 4 00000102 11223344 0 00001004 12345000 1 c3a57e19 c 33441122 0000c3a5 1 0 0
1 0 0 2 00000100 11223344 0 00001004 12345000 1 c3a57e19 f 11223344 c3a57e19 1 0 0
1 0 0 0 00000201 11223344 0 00001004 12345000 1 17f09e42 2 22334411 ffffff9e 1 0 0
1 0 0 1 00000200 11223344 0 00001004 12345000 1 17f09e42 3 11223344 ffff9e42 1 0 0
1 0 0 4 00000200 11223344 0 00001004 12345000 1 17f09e42 3 11223344 00009e42 1 0 0
1 0 0 1 00000202 11223344 0 00001004 12345000 1 17f09e42 c 33441122 000017f0 1 0 0
1 0 0 3 00000203 11223344 0 00001004 12345000 1 17f09e42 8 44112233 00000017 1 0 0
1 0 0 2 00000301 11223344 3 00001004 12345000 1 17f09e42 0 22334411 00000301 1 1 0
1 0 0 2 00000302 11223344 3 00001004 12345000 1 17f09e42 0 33441122 00000302 1 1 0
1 0 0 1 00000303 11223344 3 00001004 12345000 1 17f09e42 0 44112233 00000303 1 1 0
0 1 0 0 00000400 11223344 3 00001004 12345000 0 00000000 1 11223344 00000400 0 0 0
0 1 0 0 00000401 11223344 3 00001004 12345000 0 00000000 2 22334411 00000401 0 0 0
0 1 0 0 00000402 11223344 3 00001004 12345000 0 00000000 4 33441122 00000402 0 0 0
0 1 0 0 00000403 11223344 3 00001004 12345000 0 00000000 8 44112233 00000403 0 0 0
0 1 0 1 00000402 11223344 3 00001004 12345000 0 00000000 c 33441122 00000402 0 0 0
0 1 0 2 00000400 deadbeef 3 00001004 12345000 0 00000000 f deadbeef 00000400 0 0 0
0 1 0 2 00000402 11223344 3 00001004 12345000 0 00000000 0 33441122 00000402 0 0 1
0 1 0 1 00000401 11223344 3 00001004 12345000 0 00000000 0 22334411 00000401 0 0 1
0 0 0 7 00000500 11223344 1 00001004 12345000 1 00000000 0 11223344 00001004 1 0 0
0 0 0 7 00000500 11223344 2 00001004 12345000 1 00000000 0 11223344 12345000 1 0 0
0 0 0 7 00000500 11223344 5 00001004 12345000 1 00000000 0 11223344 00000000 1 0 0
1 0 1 2 00000600 11223344 0 00001004 12345000 1 c3a57e19 f 11223344 c3a57e19 0 0 0
0 1 1 2 00000604 11223344 3 00001004 12345000 1 00000000 f 11223344 00000604 0 0 0
